// File: list.f
cache_geom_pkg.sv
cache_bus_pkg.sv
tag_array.sv
data_array.sv
repl_state.sv
wb_buffer.sv
dcache_ctrl.sv
dcache_top.sv
tb_mem_model.sv
tb_dcache.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing
TOP      = tb_dcache
FILELIST = list.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with $(SIM)"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: tb_dcache.sv
`default_nettype none
`timescale 1ns/100ps

module tb_dcache import cache_geom_pkg::*, cache_bus_pkg::*; ();

    localparam int MAX_CYCLES = 20000;   // ~200 accesses, 100 cycles each at worst

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic        req_valid = 1'b0;
    cpu_req_t    cpu_req = '0;
    logic        addr_ok;
    cpu_resp_t   resp;
    mem_rd_req_t rd_req;
    logic        rd_rdy;
    logic        ret_valid;
    line_t       ret_line;
    mem_wr_req_t wr_req;
    logic        wr_rdy;
    logic        bvalid;
    logic [3:0]  gate = '0;
    logic [31:0] gate_lfsr = 32'h66ea;
    logic [31:0] stim_lfsr = 32'h66ea;
    int          cycles = 0;
    word_t       sb [logic [29:0]];    // expected value of every stored word
    mem_wr_req_t wb_seen [$];

    always #10 clk = ~clk;

    dcache_top dut_i (
        .clk(clk), .reset(reset),
        .req_valid_i(req_valid), .req_i(cpu_req),
        .addr_ok_o(addr_ok), .resp_o(resp),
        .rd_req_o(rd_req), .rd_rdy_i(rd_rdy),
        .ret_valid_i(ret_valid), .ret_line_i(ret_line),
        .wr_req_o(wr_req), .wr_rdy_i(wr_rdy), .bvalid_i(bvalid)
    );

    tb_mem_model mem_i (
        .clk(clk), .reset(reset), .gate_i(gate),
        .rd_req_i(rd_req), .rd_rdy_o(rd_rdy),
        .ret_valid_o(ret_valid), .ret_line_o(ret_line),
        .wr_req_i(wr_req), .wr_rdy_o(wr_rdy), .bvalid_o(bvalid)
    );

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32,22,2,1
    endfunction

    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_next(stim_lfsr);
            v = {v[30:0], stim_lfsr[0]};
        end
        return v;
    endfunction

    function automatic word_t initial_word(logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ 32'h5a5a_0000;
    endfunction

    function automatic word_t expected_word(logic [31:0] addr);
        if (sb.exists(addr[31:2])) begin
            return sb[addr[31:2]];
        end
        return initial_word(addr);
    endfunction

    function automatic word_t merge_bytes(word_t old, word_t wdata, strb_t strb);
        word_t w;
        w = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) w[i*8 +: 8] = wdata[i*8 +: 8];
        end
        return w;
    endfunction

    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic compare_word(string name, word_t exp, word_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic verify_latency(string name, int exp, int act);
        if (act != exp) begin
            $display("[FAIL] %s: expected latency %0d, actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_writeback(string name, mem_wr_req_t exp, mem_wr_req_t act);
        if (act.addr !== exp.addr || act.data !== exp.data) begin
            $display("[FAIL] %s: expected %h / %h, actual %h / %h",
                     name, exp.addr.raw, exp.data, act.addr.raw, act.data);
            abort_run();
        end
    endtask

    // free-running ready gates and refill delay for the memory model
    always @(posedge clk) begin : gate_step
        logic [3:0] g;
        for (int i = 0; i < 4; i++) begin
            gate_lfsr = lfsr_next(gate_lfsr);
            g[i] = gate_lfsr[0];
        end
        gate <= g;
    end

    always @(posedge clk) begin
        if (wr_req.req && wr_rdy) wb_seen.push_back(wr_req);   // accepted write-backs
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    // one request, returns read word and cycles from acceptance to data_ok
    task automatic cpu_access(input cpu_req_t r, output word_t rdata, output int lat);
        req_valid <= 1'b1;
        cpu_req   <= r;
        @(posedge clk);
        while (!addr_ok) @(posedge clk);
        req_valid <= 1'b0;
        lat = 0;
        @(posedge clk);
        lat++;
        while (!resp.data_ok) begin
            @(posedge clk);
            lat++;
        end
        rdata = resp.rdata;
        @(posedge clk);
        if (resp.data_ok) begin
            $display("data_ok stayed high for more than one cycle");
            abort_run();
        end
    endtask

    task automatic load_check(string name, logic [31:0] addr, bit hit);
        cpu_req_t r;
        word_t    rdata;
        int       lat;
        r          = '0;
        r.addr.raw = addr;
        cpu_access(r, rdata, lat);
        if (hit) verify_latency(name, 1, lat);
        compare_word(name, expected_word(addr), rdata);
    endtask

    task automatic store_word(string name, logic [31:0] addr, strb_t strb, word_t wdata, bit hit);
        cpu_req_t r;
        word_t    rdata;
        int       lat;
        r.we       = 1'b1;
        r.addr.raw = addr;
        r.strb     = strb;
        r.wdata    = wdata;
        cpu_access(r, rdata, lat);
        if (hit) verify_latency(name, 1, lat);
        sb[addr[31:2]] = merge_bytes(expected_word(addr), wdata, strb);
    endtask

    task automatic read_miss();
        load_check("read_miss", 32'h0000_1044, 1'b0);   // set 2
    endtask

    task automatic read_hit();
        for (int i = 0; i < LINE_WORDS; i++) begin
            load_check("read_hit", 32'h0000_1040 + 32'(4 * i), 1'b1);
        end
    endtask

    task automatic store_hit();
        store_word("store_hit", 32'h0000_1048, 4'b0101, 32'hdead_beef, 1'b1);
        load_check("store_hit", 32'h0000_1048, 1'b1);
    endtask

    task automatic store_miss();
        store_word("store_miss", 32'h0000_2064, 4'b1110, 32'hcafe_f00d, 1'b0);
        for (int i = 0; i < LINE_WORDS; i++) begin
            load_check("store_miss", 32'h0000_2060 + 32'(4 * i), 1'b1);
        end
    endtask

    // three tags in set 5, the third store pushes out the first line
    task automatic dirty_eviction();
        mem_wr_req_t exp;
        exp = '0;
        wb_seen.delete();
        store_word("dirty_eviction", 32'h0000_30a4, 4'b1111, 32'h1111_1111, 1'b0);
        store_word("dirty_eviction", 32'h0000_40a8, 4'b0011, 32'h2222_2222, 1'b0);
        exp.req      = 1'b1;
        exp.addr.raw = 32'h0000_30a0;
        for (int i = 0; i < LINE_WORDS; i++) begin
            exp.data[i*32 +: 32] = expected_word(32'h0000_30a0 + 32'(4 * i));
        end
        store_word("dirty_eviction", 32'h0000_50ac, 4'b1000, 32'h3333_3333, 1'b0);
        while (wb_seen.size() == 0) @(posedge clk);
        check_writeback("dirty_eviction", exp, wb_seen.pop_front());
        load_check("dirty_eviction", 32'h0000_30a4, 1'b0);   // refetched from memory
        load_check("dirty_eviction", 32'h0000_30a0, 1'b1);
    endtask

    task automatic random_traffic();
        addr_u a;
        logic  we;
        strb_t strb;
        word_t wdata;
        for (int n = 0; n < 150; n++) begin
            a.raw     = '0;
            a.f.tag   = 20'h00010 + 20'(take_bits(2));
            a.f.index = 7'd8 + 7'(take_bits(2));
            a.f.woff  = 3'(take_bits(3));
            we        = 1'(take_bits(1));
            strb      = 4'(take_bits(4));
            wdata     = take_bits(32);
            if (we) begin
                store_word("random_traffic", a.raw, strb, wdata, 1'b0);
            end else begin
                load_check("random_traffic", a.raw, 1'b0);
            end
        end
    endtask

    initial begin
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        read_miss();
        read_hit();
        store_hit();
        store_miss();
        dirty_eviction();
        random_traffic();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_mem_model.sv
`default_nettype none
`timescale 1ns/100ps

module tb_mem_model import cache_geom_pkg::*, cache_bus_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [3:0]  gate_i,      // rd ready, wr ready, refill delay
    input  mem_rd_req_t rd_req_i,
    output logic        rd_rdy_o,
    output logic        ret_valid_o,
    output line_t       ret_line_o,
    input  mem_wr_req_t wr_req_i,
    output logic        wr_rdy_o,
    output logic        bvalid_o
);

    word_t      mem [logic [29:0]];   // only words written back
    logic       rd_busy_q = 1'b0;
    logic [2:0] rd_cnt_q = '0;
    logic       ret_valid_q = 1'b0;
    line_t      ret_line_q = '0;
    logic       wr_busy_q = 1'b0;
    logic       bvalid_q = 1'b0;

    function automatic word_t read_word(logic [29:0] wa);
        if (mem.exists(wa)) begin
            return mem[wa];
        end
        return {wa, 2'b00} ^ 32'h5a5a_0000;   // untouched memory pattern
    endfunction

    function automatic line_t read_line(logic [26:0] la);
        line_t l;
        for (int i = 0; i < LINE_WORDS; i++) begin
            l[i*32 +: 32] = read_word({la, 3'(i)});
        end
        return l;
    endfunction

    // refill and write-back share one block so memory order is fixed
    always @(posedge clk) begin
        if (reset) begin
            rd_busy_q   <= 1'b0;
            ret_valid_q <= 1'b0;
            wr_busy_q   <= 1'b0;
            bvalid_q    <= 1'b0;
        end else begin
            ret_valid_q <= 1'b0;
            if (rd_busy_q) begin
                rd_cnt_q <= rd_cnt_q - 3'd1;
                if (rd_cnt_q == 3'd1) begin
                    ret_valid_q <= 1'b1;
                    rd_busy_q   <= 1'b0;
                end
            end else if (rd_req_i.req && rd_rdy_o) begin
                rd_busy_q  <= 1'b1;
                rd_cnt_q   <= 3'd3 + 3'(gate_i[3:2]);   // 3 to 6 cycles
                ret_line_q <= read_line(rd_req_i.addr.raw[31:5]);
            end

            bvalid_q <= 1'b0;
            if (bvalid_q) begin
                wr_busy_q <= 1'b0;
            end else if (wr_busy_q) begin
                bvalid_q <= 1'b1;
            end else if (wr_req_i.req && wr_rdy_o) begin
                wr_busy_q <= 1'b1;
                for (int i = 0; i < LINE_WORDS; i++) begin
                    mem[{wr_req_i.addr.raw[31:5], 3'(i)}] = wr_req_i.data[i*32 +: 32];
                end
            end
        end
    end

    assign rd_rdy_o    = gate_i[0] && !rd_busy_q;
    assign ret_valid_o = ret_valid_q;
    assign ret_line_o  = ret_line_q;
    assign wr_rdy_o    = gate_i[1] && !wr_busy_q;
    assign bvalid_o    = bvalid_q;

endmodule

`default_nettype wire

// File: dcache_top.sv
`default_nettype none
`timescale 1ns/100ps

module dcache_top import cache_geom_pkg::*, cache_bus_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        req_valid_i,
    input  cpu_req_t    req_i,
    output logic        addr_ok_o,
    output cpu_resp_t   resp_o,
    output mem_rd_req_t rd_req_o,
    input  logic        rd_rdy_i,
    input  logic        ret_valid_i,
    input  line_t       ret_line_i,
    output mem_wr_req_t wr_req_o,
    input  logic        wr_rdy_i,
    input  logic        bvalid_i
);

    index_t                     rd_index;
    tagv_t [NUM_WAYS-1:0]       tagv;
    line_t [NUM_WAYS-1:0]       line;
    arr_wr_t                    arr_wr;
    repl_upd_t                  repl_upd;
    logic                       victim_way;
    logic                       victim_dirty;
    logic                       wb_busy;
    logic                       wb_capture;
    addr_u                      wb_addr;
    line_t                      wb_line;

    dcache_ctrl ctrl_i (
        .clk(clk), .reset(reset),
        .req_valid_i(req_valid_i), .req_i(req_i),
        .addr_ok_o(addr_ok_o), .resp_o(resp_o),
        .rd_index_o(rd_index), .tagv_i(tagv), .line_i(line),
        .arr_wr_o(arr_wr),
        .victim_way_i(victim_way), .victim_dirty_i(victim_dirty),
        .repl_upd_o(repl_upd),
        .wb_busy_i(wb_busy), .wb_capture_o(wb_capture),
        .wb_addr_o(wb_addr), .wb_line_o(wb_line),
        .rd_req_o(rd_req_o), .rd_rdy_i(rd_rdy_i),
        .ret_valid_i(ret_valid_i), .ret_line_i(ret_line_i)
    );

    tag_array tag_i (
        .clk(clk), .reset(reset),
        .rd_index_i(rd_index), .wr_i(arr_wr), .tagv_o(tagv)
    );

    data_array data_i (
        .clk(clk), .rd_index_i(rd_index), .wr_i(arr_wr), .line_o(line)
    );

    repl_state repl_i (
        .clk(clk), .reset(reset),
        .upd_i(repl_upd), .index_i(repl_upd.index),   // latched index
        .victim_way_o(victim_way), .victim_dirty_o(victim_dirty)
    );

    wb_buffer wb_i (
        .clk(clk), .reset(reset),
        .capture_i(wb_capture), .addr_i(wb_addr), .line_i(wb_line),
        .busy_o(wb_busy), .wr_req_o(wr_req_o),
        .wr_rdy_i(wr_rdy_i), .bvalid_i(bvalid_i)
    );

endmodule

`default_nettype wire

// File: dcache_ctrl.sv
`default_nettype none
`timescale 1ns/100ps

module dcache_ctrl import cache_geom_pkg::*, cache_bus_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 req_valid_i,
    input  cpu_req_t             req_i,
    output logic                 addr_ok_o,
    output cpu_resp_t            resp_o,
    output index_t               rd_index_o,
    input  tagv_t [NUM_WAYS-1:0] tagv_i,
    input  line_t [NUM_WAYS-1:0] line_i,
    output arr_wr_t              arr_wr_o,
    input  logic                 victim_way_i,
    input  logic                 victim_dirty_i,
    output repl_upd_t            repl_upd_o,
    input  logic                 wb_busy_i,
    output logic                 wb_capture_o,
    output addr_u                wb_addr_o,
    output line_t                wb_line_o,
    output mem_rd_req_t          rd_req_o,
    input  logic                 rd_rdy_i,
    input  logic                 ret_valid_i,
    input  line_t                ret_line_i
);

    typedef enum logic [2:0] {IDLE, LOOKUP, EVICT, REFILL_REQ, REFILL_WAIT, FILL} state_t;

    state_t              state_q, state_d;
    logic                addr_ok_q;
    cpu_req_t            req_q;
    line_t               fill_line_q;
    logic [31:5]         wb_line_addr_q;   // line held by the write-back buffer
    logic [NUM_WAYS-1:0] hit_way;
    logic                hit;
    logic                wb_hazard;
    word_t               mask;
    line_t               merged;
    line_t               rd_line;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q   <= IDLE;
            addr_ok_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            addr_ok_q <= (state_d == IDLE);
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid_i && addr_ok_q) begin
            req_q <= req_i;
        end
        if (state_q == REFILL_WAIT && ret_valid_i) begin
            fill_line_q <= ret_line_i;
        end
        if (wb_capture_o) begin
            wb_line_addr_q <= wb_addr_o.raw[31:5];
        end
    end

    assign addr_ok_o  = addr_ok_q;
    assign rd_index_o = (state_q == IDLE) ? req_i.addr.f.index : req_q.addr.f.index;

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_hit
        assign hit_way[w] = tagv_i[w].valid && (tagv_i[w].tag == req_q.addr.f.tag);
    end
    assign hit = |hit_way;

    // refill must not overtake a pending write-back of the same line
    assign wb_hazard = wb_busy_i && (wb_line_addr_q == req_q.addr.raw[31:5]);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:        if (req_valid_i && addr_ok_q) state_d = LOOKUP;
            LOOKUP:      if (hit) state_d = IDLE;
                         else     state_d = victim_dirty_i ? EVICT : REFILL_REQ;
            EVICT:       if (!wb_busy_i) state_d = REFILL_REQ;
            REFILL_REQ:  if (rd_rdy_i && !wb_hazard) state_d = REFILL_WAIT;
            REFILL_WAIT: if (ret_valid_i) state_d = FILL;
            FILL:        state_d = IDLE;
            default:     state_d = IDLE;
        endcase
    end

    // store word merged into the fetched line
    assign mask = {{8{req_q.strb[3]}}, {8{req_q.strb[2]}}, {8{req_q.strb[1]}}, {8{req_q.strb[0]}}};
    always_comb begin
        merged = fill_line_q;
        if (req_q.we) begin
            merged[req_q.addr.f.woff*32 +: 32] =
                (req_q.wdata & mask) | (fill_line_q[req_q.addr.f.woff*32 +: 32] & ~mask);
        end
    end

    always_comb begin
        arr_wr_o            = '0;
        arr_wr_o.index      = req_q.addr.f.index;
        arr_wr_o.tagv.valid = 1'b1;
        arr_wr_o.tagv.tag   = req_q.addr.f.tag;
        if (state_q == LOOKUP && hit && req_q.we) begin
            arr_wr_o.way_en                    = hit_way;
            arr_wr_o.strb[req_q.addr.f.woff]   = req_q.strb;
            arr_wr_o.line                      = {LINE_WORDS{req_q.wdata}};
        end else if (state_q == FILL) begin
            arr_wr_o.way_en[victim_way_i] = 1'b1;
            arr_wr_o.strb                 = '1;
            arr_wr_o.line                 = merged;
        end
    end

    assign repl_upd_o.hit_en   = (state_q == LOOKUP) && hit;
    assign repl_upd_o.hit_way  = hit_way[1];
    assign repl_upd_o.fill_en  = (state_q == FILL);
    assign repl_upd_o.fill_way = victim_way_i;
    assign repl_upd_o.index    = req_q.addr.f.index;
    assign repl_upd_o.store    = req_q.we;

    // arrays keep reading the latched index, so line_i is the victim here
    assign wb_capture_o  = (state_q == EVICT) && !wb_busy_i;
    assign wb_addr_o.raw = {tagv_i[victim_way_i].tag, req_q.addr.f.index, 5'b0};
    assign wb_line_o     = line_i[victim_way_i];

    assign rd_req_o.req      = (state_q == REFILL_REQ) && !wb_hazard;
    assign rd_req_o.addr.raw = {req_q.addr.raw[31:5], 5'b0};

    assign rd_line        = (state_q == FILL) ? fill_line_q : line_i[hit_way[1]];
    assign resp_o.data_ok = ((state_q == LOOKUP) && hit) || (state_q == FILL);
    assign resp_o.rdata   = rd_line[req_q.addr.f.woff*32 +: 32];

endmodule

`default_nettype wire

// File: wb_buffer.sv
`default_nettype none
`timescale 1ns/100ps

module wb_buffer import cache_geom_pkg::*, cache_bus_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        capture_i,
    input  addr_u       addr_i,
    input  line_t       line_i,
    output logic        busy_o,
    output mem_wr_req_t wr_req_o,
    input  logic        wr_rdy_i,
    input  logic        bvalid_i
);

    logic  busy_q;
    logic  req_q;
    addr_u addr_q;
    line_t line_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q <= 1'b0;
            req_q  <= 1'b0;
        end else if (capture_i) begin
            busy_q <= 1'b1;
            req_q  <= 1'b1;
        end else begin
            if (req_q && wr_rdy_i) req_q <= 1'b0;    // request taken
            if (bvalid_i) busy_q <= 1'b0;            // write done
        end
    end

    always_ff @(posedge clk) begin
        if (capture_i) begin
            addr_q <= addr_i;
            line_q <= line_i;
        end
    end

    assign busy_o        = busy_q;
    assign wr_req_o.req  = req_q;
    assign wr_req_o.addr = addr_q;
    assign wr_req_o.data = line_q;

endmodule

`default_nettype wire

// File: repl_state.sv
`default_nettype none
`timescale 1ns/100ps

module repl_state import cache_geom_pkg::*, cache_bus_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  repl_upd_t upd_i,
    input  index_t    index_i,
    output logic      victim_way_o,
    output logic      victim_dirty_o
);

    logic [NUM_SETS-1:0]                lru_q;     // way to replace next
    logic [NUM_WAYS-1:0][NUM_SETS-1:0]  dirty_q;
    logic                               upd_way;

    assign upd_way = upd_i.hit_en ? upd_i.hit_way : upd_i.fill_way;

    always_ff @(posedge clk) begin
        if (reset) begin
            lru_q   <= '0;
            dirty_q <= '0;
        end else if (upd_i.hit_en || upd_i.fill_en) begin
            lru_q[upd_i.index] <= ~upd_way;
            if (upd_i.store) begin
                dirty_q[upd_way][upd_i.index] <= 1'b1;
            end else if (upd_i.fill_en) begin
                dirty_q[upd_way][upd_i.index] <= 1'b0;   // clean refill
            end
        end
    end

    assign victim_way_o   = lru_q[index_i];
    assign victim_dirty_o = dirty_q[victim_way_o][index_i];

endmodule

`default_nettype wire

// File: data_array.sv
`default_nettype none
`timescale 1ns/100ps

module data_array import cache_geom_pkg::*, cache_bus_pkg::*; (
    input  logic                 clk,
    input  index_t               rd_index_i,
    input  arr_wr_t              wr_i,
    output line_t [NUM_WAYS-1:0] line_o
);

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        for (genvar b = 0; b < LINE_WORDS; b++) begin : g_bank
            word_t bank [NUM_SETS];   // one word of every line
            word_t rd_q;

            always_ff @(posedge clk) begin
                for (int i = 0; i < 4; i++) begin
                    if (wr_i.way_en[w] && wr_i.strb[b][i]) begin
                        bank[wr_i.index][i*8 +: 8] <= wr_i.line[b*32 + i*8 +: 8];
                    end
                end
            end

            // read before write on the same index
            always_ff @(posedge clk) begin
                rd_q <= bank[rd_index_i];
            end

            assign line_o[w][b*32 +: 32] = rd_q;
        end
    end

endmodule

`default_nettype wire

// File: tag_array.sv
`default_nettype none
`timescale 1ns/100ps

module tag_array import cache_geom_pkg::*, cache_bus_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  index_t               rd_index_i,
    input  arr_wr_t              wr_i,
    output tagv_t [NUM_WAYS-1:0] tagv_o
);

    logic any_strb;

    assign any_strb = |wr_i.strb;

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        tag_t                tag_mem [NUM_SETS];
        logic [NUM_SETS-1:0] valid_q;   // cleared on reset
        logic                wr_en;

        assign wr_en = wr_i.way_en[w] && any_strb;

        always_ff @(posedge clk) begin
            if (wr_en) begin
                tag_mem[wr_i.index] <= wr_i.tagv.tag;
            end
        end

        always_ff @(posedge clk) begin
            if (reset) begin
                valid_q <= '0;
            end else if (wr_en) begin
                valid_q[wr_i.index] <= wr_i.tagv.valid;
            end
        end

        always_ff @(posedge clk) begin
            tagv_o[w].valid <= valid_q[rd_index_i];
            tagv_o[w].tag   <= tag_mem[rd_index_i];
        end
    end

endmodule

`default_nettype wire

// File: cache_bus_pkg.sv
`default_nettype none

package cache_bus_pkg;

    import cache_geom_pkg::*;

    typedef struct packed {
        logic  we;      // 1 = store
        addr_u addr;
        strb_t strb;
        word_t wdata;
    } cpu_req_t;

    typedef struct packed {
        logic  data_ok;
        word_t rdata;
    } cpu_resp_t;

    typedef struct packed {
        logic  req;
        addr_u addr;    // line aligned
    } mem_rd_req_t;

    typedef struct packed {
        logic  req;
        addr_u addr;    // line aligned
        line_t data;
    } mem_wr_req_t;

    typedef struct packed {
        index_t                     index;
        logic [NUM_WAYS-1:0]        way_en;
        strb_t [LINE_WORDS-1:0]     strb;    // byte enables per word
        line_t                      line;
        tagv_t                      tagv;
    } arr_wr_t;

    typedef struct packed {
        logic   hit_en;
        logic   hit_way;
        logic   fill_en;
        logic   fill_way;
        index_t index;
        logic   store;
    } repl_upd_t;

endpackage

`default_nettype wire

// File: cache_geom_pkg.sv
`default_nettype none

package cache_geom_pkg;

    localparam int NUM_WAYS   = 2;
    localparam int NUM_SETS   = 128;
    localparam int LINE_WORDS = 8;

    localparam int TAG_W   = 20;
    localparam int INDEX_W = 7;
    localparam int WOFF_W  = 3;

    typedef logic [31:0]               word_t;
    typedef logic [LINE_WORDS*32-1:0]  line_t;   // word 0 in low bits
    typedef logic [TAG_W-1:0]          tag_t;
    typedef logic [INDEX_W-1:0]        index_t;
    typedef logic [3:0]                strb_t;

    typedef struct packed {
        tag_t              tag;
        index_t            index;
        logic [WOFF_W-1:0] woff;
        logic [1:0]        boff;
    } addr_fields_t;

    // lookup uses the fields, memory requests use the raw word
    typedef union packed {
        logic [31:0]  raw;
        addr_fields_t f;
    } addr_u;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tagv_t;

endpackage

`default_nettype wire
